//--- common/copy_defines.svh
// Line copy engine definitions
`ifndef COPY_DEFINES_SVH
`define COPY_DEFINES_SVH

// ==============================
// widths
// ==============================
`define COPY_LINE_ADDR_BITS 42
// a line is 64 bytes, so byte addresses carry 6 extra low bits
`define COPY_BYTE_IDX_BITS 6
`define COPY_LINE_BITS 512
`define COPY_LEN_BITS 16
`define COPY_CSR_IDX_BITS 3

// ==============================
// register indices
// ==============================
`define COPY_CSR_IN_ADDR 3'd0
`define COPY_CSR_LENGTH 3'd1
`define COPY_CSR_OUT_ADDR 3'd2
`define COPY_CSR_START 3'd4

`endif

//--- common/copy_pkg.sv
// Line copy engine types
`include "copy_defines.svh"

package copy_pkg;

    // ==============================
    // addresses
    // ==============================

    // address of one 512-bit line
    typedef logic [`COPY_LINE_ADDR_BITS-1:0] line_addr_t;

    // byte address as written by software holds the line address above the offset bits
    typedef logic [`COPY_LINE_ADDR_BITS+`COPY_BYTE_IDX_BITS-1:0] byte_addr_t;

    // ==============================
    // payload and counts
    // ==============================

    // one full data line
    typedef logic [`COPY_LINE_BITS-1:0] line_data_t;

    // number of lines, also used as a line index
    typedef logic [`COPY_LEN_BITS-1:0] line_count_t;

    // ==============================
    // configuration writes
    // ==============================

    typedef logic [`COPY_CSR_IDX_BITS-1:0] csr_idx_t;

    // software always writes full 64-bit words
    typedef logic [63:0] csr_data_t;

endpackage

//--- logic/csr_regs.sv
// Configuration registers
`timescale 1ns/1ps
`include "copy_defines.svh"

module csr_regs
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_wr_en,
    input  copy_pkg::csr_idx_t    csr_wr_idx,
    input  copy_pkg::csr_data_t   csr_wr_data,
    output copy_pkg::line_addr_t  input_addr,
    output copy_pkg::line_count_t input_length,
    output copy_pkg::line_addr_t  output_addr,
    output logic                  start
);
    import copy_pkg::*;

    // low bits of the write data seen as a byte address
    byte_addr_t wr_byte_addr;

    // drop the byte offset since the engine only works on whole lines
    function automatic line_addr_t to_line_addr(byte_addr_t addr);
        return addr[`COPY_BYTE_IDX_BITS +: `COPY_LINE_ADDR_BITS];
    endfunction

    assign wr_byte_addr = csr_wr_data[$bits(byte_addr_t)-1:0];

    // ==============================
    // register writes
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            input_addr <= '0;
            input_length <= '0;
            output_addr <= '0;
            start <= 1'b0;
        end
        else
        begin
            if (csr_wr_en && csr_wr_idx == `COPY_CSR_IN_ADDR)
            begin
                input_addr <= to_line_addr(wr_byte_addr);
            end
            if (csr_wr_en && csr_wr_idx == `COPY_CSR_LENGTH)
            begin
                input_length <= csr_wr_data[`COPY_LEN_BITS-1:0];
            end
            if (csr_wr_en && csr_wr_idx == `COPY_CSR_OUT_ADDR)
            begin
                output_addr <= to_line_addr(wr_byte_addr);
            end
            // start is a one-cycle strobe that ignores the data word
            start <= csr_wr_en && (csr_wr_idx == `COPY_CSR_START);
        end
    end

    // back-to-back start writes would restart a run that has not begun
    assert property (@(posedge clk) disable iff (reset)
        start |-> !(csr_wr_en && csr_wr_idx == `COPY_CSR_START));

endmodule

//--- logic/copy_fsm.sv
// Copy controller
`timescale 1ns/1ps

module copy_fsm
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic all_done,
    input  logic line_ready,
    input  logic wr_ack,
    output logic rd_go,
    output logic wr_go,
    output logic done
);
    typedef enum logic [1:0]
    {
        IDLE,
        RUN,
        WAIT_WRITE,
        DONE
    } state_t;

    state_t state;

    // set in RUN between rd_go and line_ready
    logic read_open;

    // ==============================
    // sequencing
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            read_open <= 1'b0;
            rd_go <= 1'b0;
            wr_go <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            // strobes last a single cycle
            rd_go <= 1'b0;
            wr_go <= 1'b0;
            case (state)
                IDLE:
                begin
                    // done holds from the last run until a new start
                    if (start)
                    begin
                        done <= 1'b0;
                        state <= RUN;
                    end
                end
                RUN:
                begin
                    if (!read_open)
                    begin
                        // count is already up to date after the last wr_ack
                        if (all_done)
                        begin
                            state <= DONE;
                        end
                        else
                        begin
                            rd_go <= 1'b1;
                            read_open <= 1'b1;
                        end
                    end
                    else if (line_ready)
                    begin
                        // captured line goes straight out as a write
                        read_open <= 1'b0;
                        wr_go <= 1'b1;
                        state <= WAIT_WRITE;
                    end
                end
                WAIT_WRITE:
                begin
                    // next read only after the write response keeps one line in flight
                    if (wr_ack)
                    begin
                        state <= RUN;
                    end
                end
                DONE:
                begin
                    done <= 1'b1;
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // no write may be started before the line it carries has arrived
    assert property (@(posedge clk) disable iff (reset)
        rd_go |=> (!wr_go until_with line_ready));

endmodule

//--- logic/line_counter.sv
// Completed line counter
`timescale 1ns/1ps

module line_counter
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  step,
    input  copy_pkg::line_count_t input_length,
    output copy_pkg::line_count_t line_index,
    output logic                  all_done
);
    import copy_pkg::*;

    line_count_t count;

    // ==============================
    // count
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (start)
        begin
            count <= '0;
        end
        else if (step)
        begin
            count <= count + line_count_t'(1);
        end
    end

    // index of the next line to copy, and the number written so far
    assign line_index = count;
    assign all_done = (count == input_length);

    // the controller must stop once every line has been acknowledged
    assert property (@(posedge clk) disable iff (reset)
        step |-> !all_done);

endmodule

//--- mover/read_requester.sv
// Read request and line capture
`timescale 1ns/1ps

module read_requester
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_go,
    input  copy_pkg::line_addr_t  input_addr,
    input  copy_pkg::line_count_t line_index,
    input  logic                  rd_almost_full,
    input  logic                  rd_rsp_valid,
    input  copy_pkg::line_data_t  rd_rsp_data,
    output logic                  rd_req_valid,
    output copy_pkg::line_addr_t  rd_req_addr,
    output logic                  line_ready,
    output copy_pkg::line_data_t  line_data
);
    import copy_pkg::*;

    // a read has been asked for but not yet sent
    logic pending;

    // ==============================
    // request issue
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending <= 1'b0;
        end
        else if (rd_go)
        begin
            pending <= 1'b1;
        end
        else if (!rd_almost_full)
        begin
            // sent this cycle if it was pending
            pending <= 1'b0;
        end
    end

    // held back while memory signals almost-full
    assign rd_req_valid = pending && !rd_almost_full;
    assign rd_req_addr = input_addr + line_addr_t'(line_index);

    // ==============================
    // response capture
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_ready <= 1'b0;
        end
        else
        begin
            line_ready <= rd_rsp_valid;
        end
    end

    // only one line is ever in flight, so this register is never overrun
    always_ff @(posedge clk)
    begin
        if (rd_rsp_valid)
        begin
            line_data <= rd_rsp_data;
        end
    end

    // under back-pressure the request stays pending with a steady address
    assert property (@(posedge clk) disable iff (reset)
        pending && rd_almost_full |=> pending && $stable(rd_req_addr));

endmodule

//--- mover/write_requester.sv
// Write request and acknowledge
`timescale 1ns/1ps

module write_requester
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_go,
    input  copy_pkg::line_addr_t  output_addr,
    input  copy_pkg::line_count_t line_index,
    input  copy_pkg::line_data_t  line_data,
    input  logic                  wr_almost_full,
    input  logic                  wr_rsp_valid,
    output logic                  wr_req_valid,
    output copy_pkg::line_addr_t  wr_req_addr,
    output copy_pkg::line_data_t  wr_req_data,
    output logic                  wr_ack
);
    import copy_pkg::*;

    // a write has been asked for but not yet sent
    logic pending;

    // ==============================
    // request issue
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending <= 1'b0;
        end
        else if (wr_go)
        begin
            pending <= 1'b1;
        end
        else if (!wr_almost_full)
        begin
            pending <= 1'b0;
        end
    end

    // send only while memory has room
    assign wr_req_valid = pending && !wr_almost_full;

    // line_index only moves after wr_ack, so address holds while pending
    assign wr_req_addr = output_addr + line_addr_t'(line_index);

    // captured read line stays stable until the next read is issued
    assign wr_req_data = line_data;

    // ==============================
    // response
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ack <= 1'b0;
        end
        else
        begin
            // registered response steps the counter and releases the controller
            wr_ack <= wr_rsp_valid;
        end
    end

endmodule

//--- logic/copy_top.sv
// Line copy engine top level
`timescale 1ns/1ps

module copy_top
(
    input  logic                  clk,
    input  logic                  reset,
    // configuration writes
    input  logic                  csr_wr_en,
    input  copy_pkg::csr_idx_t    csr_wr_idx,
    input  copy_pkg::csr_data_t   csr_wr_data,
    // memory read port
    output logic                  rd_req_valid,
    output copy_pkg::line_addr_t  rd_req_addr,
    input  logic                  rd_almost_full,
    input  logic                  rd_rsp_valid,
    input  copy_pkg::line_data_t  rd_rsp_data,
    // memory write port
    output logic                  wr_req_valid,
    output copy_pkg::line_addr_t  wr_req_addr,
    output copy_pkg::line_data_t  wr_req_data,
    input  logic                  wr_almost_full,
    input  logic                  wr_rsp_valid,
    // status
    output logic                  done,
    output copy_pkg::line_count_t lines_written
);
    import copy_pkg::*;

    // configuration values
    line_addr_t  input_addr;
    line_addr_t  output_addr;
    line_count_t input_length;

    // steering strobes and levels
    logic        start;
    logic        rd_go;
    logic        wr_go;
    logic        line_ready;
    logic        wr_ack;
    logic        all_done;
    line_count_t line_index;
    line_data_t  line_data;

    // ==============================
    // control
    // ==============================
    csr_regs u_csr_regs
    (
        .clk          (clk),
        .reset        (reset),
        .csr_wr_en    (csr_wr_en),
        .csr_wr_idx   (csr_wr_idx),
        .csr_wr_data  (csr_wr_data),
        .input_addr   (input_addr),
        .input_length (input_length),
        .output_addr  (output_addr),
        .start        (start)
    );

    copy_fsm u_copy_fsm
    (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .all_done   (all_done),
        .line_ready (line_ready),
        .wr_ack     (wr_ack),
        .rd_go      (rd_go),
        .wr_go      (wr_go),
        .done       (done)
    );

    // counter steps on each acknowledged write
    line_counter u_line_counter
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .step         (wr_ack),
        .input_length (input_length),
        .line_index   (line_index),
        .all_done     (all_done)
    );

    // ==============================
    // memory side
    // ==============================
    read_requester u_read_requester
    (
        .clk            (clk),
        .reset          (reset),
        .rd_go          (rd_go),
        .input_addr     (input_addr),
        .line_index     (line_index),
        .rd_almost_full (rd_almost_full),
        .rd_rsp_valid   (rd_rsp_valid),
        .rd_rsp_data    (rd_rsp_data),
        .rd_req_valid   (rd_req_valid),
        .rd_req_addr    (rd_req_addr),
        .line_ready     (line_ready),
        .line_data      (line_data)
    );

    write_requester u_write_requester
    (
        .clk            (clk),
        .reset          (reset),
        .wr_go          (wr_go),
        .output_addr    (output_addr),
        .line_index     (line_index),
        .line_data      (line_data),
        .wr_almost_full (wr_almost_full),
        .wr_rsp_valid   (wr_rsp_valid),
        .wr_req_valid   (wr_req_valid),
        .wr_req_addr    (wr_req_addr),
        .wr_req_data    (wr_req_data),
        .wr_ack         (wr_ack)
    );

    // completed lines are reported straight from the counter
    assign lines_written = line_index;

endmodule

//--- bench/copy_tb.sv
// Line copy engine testbench
`timescale 1ns/1ps
`include "copy_defines.svh"

module copy_tb;
    import copy_pkg::*;

    localparam int NUM_CASES = 6;
    localparam int MEM_LINES = 1024;

    logic        clk;
    logic        reset;
    logic        csr_wr_en;
    csr_idx_t    csr_wr_idx;
    csr_data_t   csr_wr_data;
    logic        rd_req_valid;
    line_addr_t  rd_req_addr;
    logic        rd_almost_full;
    logic        rd_rsp_valid;
    line_data_t  rd_rsp_data;
    logic        wr_req_valid;
    line_addr_t  wr_req_addr;
    line_data_t  wr_req_data;
    logic        wr_almost_full;
    logic        wr_rsp_valid;
    logic        done;
    line_count_t lines_written;

    // ==============================
    // case table
    // ==============================
    // name, input byte address, length, output byte address, expected lines
    string       case_name [NUM_CASES] = '{"len_zero", "single_adjacent", "five_adjacent",
                                           "twelve_far", "five_offset_bits", "twelve_back"};
    byte_addr_t  case_in   [NUM_CASES] = '{48'h0000, 48'h0040, 48'h0400,
                                           48'h0800, 48'h2025, 48'he000};
    line_count_t case_len  [NUM_CASES] = '{16'd0, 16'd1, 16'd5, 16'd12, 16'd5, 16'd12};
    byte_addr_t  case_out  [NUM_CASES] = '{48'h1000, 48'h0080, 48'h0540,
                                           48'hf000, 48'h8010, 48'h0c00};
    int          case_exp  [NUM_CASES] = '{0, 1, 5, 12, 5, 12};

    // memory model state
    line_data_t  mem [int];
    line_data_t  golden [int];
    logic [31:0] rng_state = 32'h1f58_5648;
    int          rd_line;
    int          rd_wait = 0;
    int          wr_wait = 0;
    int          rd_af_cnt = 0;
    int          wr_af_cnt = 0;
    int          outstanding = 0;
    int          rd_count = 0;
    int          wr_count = 0;

    // region of the running case in lines
    int          cur_in_line = 0;
    int          cur_out_line = 0;
    int          cur_len = 0;

    int          error_count = 0;
    int          check_count = 0;

    copy_top uut
    (
        .clk            (clk),
        .reset          (reset),
        .csr_wr_en      (csr_wr_en),
        .csr_wr_idx     (csr_wr_idx),
        .csr_wr_data    (csr_wr_data),
        .rd_req_valid   (rd_req_valid),
        .rd_req_addr    (rd_req_addr),
        .rd_almost_full (rd_almost_full),
        .rd_rsp_valid   (rd_rsp_valid),
        .rd_rsp_data    (rd_rsp_data),
        .wr_req_valid   (wr_req_valid),
        .wr_req_addr    (wr_req_addr),
        .wr_req_data    (wr_req_data),
        .wr_almost_full (wr_almost_full),
        .wr_rsp_valid   (wr_rsp_valid),
        .done           (done),
        .lines_written  (lines_written)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // upper bits of the lcg are the better distributed ones
    function automatic int rand_below(int n);
        rng_state = lcg_next(rng_state);
        return int'(rng_state[31:16]) % n;
    endfunction

    // bursts of 1 to 4 high cycles with at least one low cycle between them
    function automatic int next_af_count(int cnt);
        if (cnt != 0)
        begin
            return cnt - 1;
        end
        if (rand_below(4) == 0)
        begin
            return 1 + rand_below(4);
        end
        return 0;
    endfunction

    function automatic bit in_region(line_addr_t addr, int base, int len);
        return (addr >= line_addr_t'(base)) && (addr < line_addr_t'(base + len));
    endfunction

    task automatic check_value(string name, logic [511:0] expected, logic [511:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_error(string what);
        error_count++;
        $display("error: %s", what);
    endtask

    task automatic csr_write(csr_idx_t idx, csr_data_t data);
        @(posedge clk);
        csr_wr_en <= 1'b1;
        csr_wr_idx <= idx;
        csr_wr_data <= data;
        @(posedge clk);
        csr_wr_en <= 1'b0;
    endtask

    // ==============================
    // memory model
    // ==============================
    always @(posedge clk)
    begin
        rd_rsp_valid <= 1'b0;
        wr_rsp_valid <= 1'b0;
        if (rd_req_valid)
        begin
            if (rd_almost_full)
                report_error("read request issued while read almost-full was high");
            if (outstanding != 0)
                report_error("read request issued while another request was outstanding");
            if (!in_region(rd_req_addr, cur_in_line, cur_len))
                report_error($sformatf("read address %0h outside input region", rd_req_addr));
            rd_line = int'(rd_req_addr);
            rd_wait = 1 + rand_below(8);
            rd_count++;
            outstanding++;
        end
        else if (rd_wait != 0)
        begin
            rd_wait--;
            if (rd_wait == 0)
            begin
                rd_rsp_valid <= 1'b1;
                rd_rsp_data <= mem[rd_line];
                outstanding--;
            end
        end
        if (wr_req_valid)
        begin
            if (wr_almost_full)
                report_error("write request issued while write almost-full was high");
            if (outstanding != 0)
                report_error("write request issued while another request was outstanding");
            if (!in_region(wr_req_addr, cur_out_line, cur_len))
                report_error($sformatf("write address %0h outside output region", wr_req_addr));
            else
                mem[int'(wr_req_addr)] = wr_req_data;
            wr_wait = 1 + rand_below(8);
            wr_count++;
            outstanding++;
        end
        else if (wr_wait != 0)
        begin
            wr_wait--;
            if (wr_wait == 0)
            begin
                wr_rsp_valid <= 1'b1;
                outstanding--;
            end
        end
        rd_af_cnt = next_af_count(rd_af_cnt);
        wr_af_cnt = next_af_count(wr_af_cnt);
        rd_almost_full <= (rd_af_cnt != 0);
        wr_almost_full <= (wr_af_cnt != 0);
    end

    // ==============================
    // one case from the table
    // ==============================
    task automatic run_case(int c);
        int         errors_before;
        int         settle;
        line_data_t exp_line;
        errors_before = error_count;
        cur_in_line = int'(case_in[c] >> `COPY_BYTE_IDX_BITS);
        cur_out_line = int'(case_out[c] >> `COPY_BYTE_IDX_BITS);
        cur_len = int'(case_len[c]);
        for (int a = 0; a < MEM_LINES; a++)
            golden[a] = mem[a];
        rd_count = 0;
        wr_count = 0;
        csr_write(`COPY_CSR_IN_ADDR, csr_data_t'(case_in[c]));
        csr_write(`COPY_CSR_LENGTH, csr_data_t'(case_len[c]));
        csr_write(`COPY_CSR_OUT_ADDR, csr_data_t'(case_out[c]));
        csr_write(`COPY_CSR_START, '0);
        // done of the last run must drop on the new start
        settle = 0;
        while (done && settle < 4)
        begin
            @(negedge clk);
            settle++;
        end
        if (done)
            report_error($sformatf("done stayed high after start in case %s", case_name[c]));
        while (!done)
            @(negedge clk);
        check_value({case_name[c], " lines_written"}, case_exp[c], lines_written);
        check_value({case_name[c], " read requests"}, case_exp[c], rd_count);
        check_value({case_name[c], " write requests"}, case_exp[c], wr_count);
        // copied lines land in the output region and everything else stays untouched
        for (int a = 0; a < MEM_LINES; a++)
        begin
            if (a >= cur_out_line && a < cur_out_line + cur_len)
                exp_line = golden[cur_in_line + a - cur_out_line];
            else
                exp_line = golden[a];
            if (mem[a] !== exp_line)
            begin
                check_value($sformatf("%s line %0d", case_name[c], a), exp_line, mem[a]);
                break;
            end
        end
        $display("case %s: %s", case_name[c], (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial
    begin
        line_data_t fill;
        int         reset_errors;
        reset = 1'b1;
        csr_wr_en = 1'b0;
        csr_wr_idx = '0;
        csr_wr_data = '0;
        rd_almost_full = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_data = '0;
        wr_almost_full = 1'b0;
        wr_rsp_valid = 1'b0;
        // each word mixes the lcg with the line address
        for (int a = 0; a < MEM_LINES; a++)
        begin
            for (int w = 0; w < 16; w++)
            begin
                rng_state = lcg_next(rng_state);
                fill[w*32 +: 32] = rng_state ^ a;
            end
            mem[a] = fill;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        reset_errors = error_count;
        check_value("reset rd_req_valid", 0, rd_req_valid);
        check_value("reset wr_req_valid", 0, wr_req_valid);
        check_value("reset done", 0, done);
        check_value("reset lines_written", 0, lines_written);
        $display("reset: %s", (error_count == reset_errors) ? "ok" : "mismatch");
        for (int c = 0; c < NUM_CASES; c++)
            run_case(c);
        $display("%0d cases, %0d checks, %0d errors", NUM_CASES, check_count, error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog allows 40 cycles per line plus a setup margin
    initial
    begin
        int limit;
        limit = 200;
        for (int c = 0; c < NUM_CASES; c++)
            limit += int'(case_len[c]) * 40;
        repeat (limit) @(posedge clk);
        $display("timeout: copy runs did not finish within %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/copy_pkg.sv
logic/csr_regs.sv
logic/copy_fsm.sv
logic/line_counter.sv
mover/read_requester.sv
mover/write_requester.sv
logic/copy_top.sv
bench/copy_tb.sv

//--- Bender.yml
package:
  name: line_copy_engine

sources:
  - include_dirs:
      - common
    files:
      - common/copy_pkg.sv
      - logic/csr_regs.sv
      - logic/copy_fsm.sv
      - logic/line_counter.sv
      - mover/read_requester.sv
      - mover/write_requester.sv
      - logic/copy_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/copy_tb.sv
